// ==== xbar_pkg.sv ====
/* Shared widths, register map and beat types for the two-port packet switch.
   Every switch module imports it, and so does the testbench. */
package xbar_pkg;

  localparam int DATA_W        = 64;                    // Stream data width
  localparam int DST_W         = 16;                    // Destination field in the header
  localparam int NUM_PORTS     = 2;                     // Inputs and outputs
  localparam int PORT_W        = $clog2(NUM_PORTS);     // Bits in an output number
  localparam int ROUTE_ENTRIES = 16;
  localparam int ROUTE_IDX_W   = $clog2(ROUTE_ENTRIES); // Indexed by dst low bits
  localparam int LOCAL_W       = 8;                     // Compared against dst upper byte
  localparam int REG_AW        = 14;
  localparam int REG_DW        = 32;

  localparam logic [REG_DW-1:0] XBAR_VERSION = 32'd1;

  // Register map, byte addresses
  localparam logic [REG_AW-1:0] REG_VERSION      = 14'h000;
  localparam logic [REG_AW-1:0] REG_NUM_PORTS    = 14'h004;
  localparam logic [REG_AW-1:0] REG_LOCAL_ADDR   = 14'h008;
  localparam logic [REG_AW-1:0] REG_ROUTE_BASE   = 14'h010; // Entry k at base + 4k
  localparam logic [REG_AW-1:0] REG_PKT_CNT_BASE = 14'h050; // Output j at base + 4j

  typedef struct packed {
    logic [DST_W-1:0] dst;
    logic [15:0]      src;
    logic [15:0]      length;
    logic [15:0]      rsvd;
  } hdr_word_t;

  // First beat of a packet is read as a header, the rest as raw payload
  typedef union packed {
    hdr_word_t         hdr;
    logic [DATA_W-1:0] raw;
  } beat_u;

  typedef struct packed {
    beat_u data;
    logic  last;   // Final beat of the packet
  } stream_beat_t;

  typedef struct packed {
    logic              valid;
    logic [PORT_W-1:0] port;   // Requested output
  } route_req_t;

  typedef logic [ROUTE_ENTRIES-1:0][PORT_W-1:0] route_table_t;

endpackage

// ==== xbar_regs.sv ====
/* Register port of the switch. Holds the local address and route table and
   returns read data with a response pulse one cycle after each mapped read. */
`timescale 1ns/1ps

module xbar_regs (
  input  logic                         clk,
  input  logic                         reset,
  input  logic                         i_reg_wr_req,
  input  logic [xbar_pkg::REG_AW-1:0]  i_reg_wr_addr,
  input  logic [xbar_pkg::REG_DW-1:0]  i_reg_wr_data,
  input  logic                         i_reg_rd_req,
  input  logic [xbar_pkg::REG_AW-1:0]  i_reg_rd_addr,
  output logic [xbar_pkg::REG_DW-1:0]  o_reg_rd_data,
  output logic                         o_reg_rd_resp,
  input  logic [xbar_pkg::REG_DW-1:0]  i_pkt_cnt [xbar_pkg::NUM_PORTS],
  output logic [xbar_pkg::LOCAL_W-1:0] o_local_addr,
  output xbar_pkg::route_table_t       o_route_table
);
  import xbar_pkg::*;

  logic [REG_AW-1:0] wr_rt_off;
  logic [REG_AW-1:0] rd_rt_off;
  logic [REG_AW-1:0] rd_cnt_off;
  logic              wr_rt_hit;
  logic              rd_rt_hit;
  logic              rd_cnt_hit;
  logic              rd_hit;
  logic [REG_DW-1:0] rd_mux;

  // Offsets into the route and counter windows; below-base addresses wrap high
  assign wr_rt_off  = i_reg_wr_addr - REG_ROUTE_BASE;
  assign rd_rt_off  = i_reg_rd_addr - REG_ROUTE_BASE;
  assign rd_cnt_off = i_reg_rd_addr - REG_PKT_CNT_BASE;

  assign wr_rt_hit  = (wr_rt_off < REG_AW'(4 * ROUTE_ENTRIES)) && (wr_rt_off[1:0] == 2'b00);
  assign rd_rt_hit  = (rd_rt_off < REG_AW'(4 * ROUTE_ENTRIES)) && (rd_rt_off[1:0] == 2'b00);
  assign rd_cnt_hit = (rd_cnt_off < REG_AW'(4 * NUM_PORTS)) && (rd_cnt_off[1:0] == 2'b00);

  // Writes land on the request edge, read-only addresses fall through
  always_ff @(posedge clk) begin
    if (reset) begin
      o_local_addr  <= '0;
      o_route_table <= '0;   // Every entry points at the uplink
    end else if (i_reg_wr_req) begin
      if (i_reg_wr_addr == REG_LOCAL_ADDR) begin
        o_local_addr <= i_reg_wr_data[LOCAL_W-1:0];
      end else if (wr_rt_hit) begin
        o_route_table[wr_rt_off[2 +: ROUTE_IDX_W]] <= i_reg_wr_data[PORT_W-1:0];
      end
    end
  end

  // Read select over the whole map
  always_comb begin
    rd_hit = 1'b1;
    rd_mux = '0;
    if (i_reg_rd_addr == REG_VERSION) begin
      rd_mux = XBAR_VERSION;
    end else if (i_reg_rd_addr == REG_NUM_PORTS) begin
      rd_mux = REG_DW'(NUM_PORTS);
    end else if (i_reg_rd_addr == REG_LOCAL_ADDR) begin
      rd_mux = REG_DW'(o_local_addr);
    end else if (rd_rt_hit) begin
      rd_mux = REG_DW'(o_route_table[rd_rt_off[2 +: ROUTE_IDX_W]]);
    end else if (rd_cnt_hit) begin
      rd_mux = i_pkt_cnt[rd_cnt_off[2 +: PORT_W]];
    end else begin
      rd_hit = 1'b0;   // Unmapped, no response
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      o_reg_rd_resp <= 1'b0;
    end else begin
      o_reg_rd_resp <= i_reg_rd_req && rd_hit;   // Single cycle pulse
    end
  end

  always_ff @(posedge clk) begin
    if (i_reg_rd_req) begin
      o_reg_rd_data <= rd_mux;
    end
  end

endmodule

// ==== xbar_route_decode.sv ====
/* Per-input route decoder. Works out the requested output from the header
   beat and holds that request until the packet's last beat is accepted. */
`timescale 1ns/1ps

module xbar_route_decode (
  input  logic                         clk,
  input  logic                         reset,
  input  xbar_pkg::stream_beat_t       i_beat,
  input  logic                         i_valid,
  input  logic                         i_accept,
  input  logic [xbar_pkg::LOCAL_W-1:0] i_local_addr,
  input  xbar_pkg::route_table_t       i_route_table,
  output xbar_pkg::route_req_t         o_req
);
  import xbar_pkg::*;

  hdr_word_t               hdr;
  logic [LOCAL_W-1:0]      dst_hi;
  logic [ROUTE_IDX_W-1:0]  dst_lo;
  logic [PORT_W-1:0]       hdr_port;
  logic [PORT_W-1:0]       held_port;
  logic                    in_pkt;

  assign hdr    = i_beat.data.hdr;   // Only meaningful while in_pkt is clear
  assign dst_hi = hdr.dst[DST_W-1 -: LOCAL_W];
  assign dst_lo = hdr.dst[ROUTE_IDX_W-1:0];

  // Foreign destinations go to the uplink, local ones through the table
  assign hdr_port = (dst_hi != i_local_addr) ? '0 : i_route_table[dst_lo];

  always_ff @(posedge clk) begin
    if (reset) begin
      in_pkt <= 1'b0;
    end else if (i_accept) begin
      in_pkt <= !i_beat.last;   // Single beat packets never enter
    end
  end

  // Latch on the header accept so table writes mid-packet do not move it
  always_ff @(posedge clk) begin
    if (i_accept && !in_pkt) begin
      held_port <= hdr_port;
    end
  end

  assign o_req.valid = in_pkt || i_valid;
  assign o_req.port  = in_pkt ? held_port : hdr_port;

endmodule

// ==== xbar_arbiter.sv ====
/* Round-robin arbiter for one output. Grants one requesting input and keeps
   the grant until that input's last beat is accepted. */
`timescale 1ns/1ps

module xbar_arbiter (
  input  logic                           clk,
  input  logic                           reset,
  input  logic [xbar_pkg::PORT_W-1:0]    i_port_id,   // Tied per instance
  input  xbar_pkg::route_req_t           i_req [xbar_pkg::NUM_PORTS],
  input  logic [xbar_pkg::NUM_PORTS-1:0] i_accept_last,
  output logic [xbar_pkg::NUM_PORTS-1:0] o_grant,
  output logic                           o_busy
);
  import xbar_pkg::*;

  logic [NUM_PORTS-1:0] want;
  logic [PORT_W-1:0]    last_win;
  logic [PORT_W-1:0]    cand;
  logic [PORT_W-1:0]    pick;
  logic                 pick_vld;
  logic                 busy;

  always_comb begin
    for (int i = 0; i < NUM_PORTS; i++) begin
      want[i] = i_req[i].valid && (i_req[i].port == i_port_id);
    end
  end

  // Search starts just after the previous winner
  always_comb begin
    pick_vld = 1'b0;
    pick     = last_win;
    cand     = last_win;
    for (int k = 1; k <= NUM_PORTS; k++) begin
      cand = PORT_W'((int'(last_win) + k) % NUM_PORTS);
      if (!pick_vld && want[cand]) begin
        pick_vld = 1'b1;
        pick     = cand;
      end
    end
  end

  assign busy   = |o_grant;
  assign o_busy = busy;

  always_ff @(posedge clk) begin
    if (reset) begin
      o_grant  <= '0;
      last_win <= PORT_W'(NUM_PORTS - 1);   // Input 0 is favoured first
    end else if (busy) begin
      if (|(o_grant & i_accept_last)) begin
        o_grant <= '0;   // Free from the next cycle
      end
    end else if (pick_vld) begin
      o_grant  <= NUM_PORTS'(1) << pick;
      last_win <= pick;
    end
  end

endmodule

// ==== xbar_output_mux.sv ====
/* Output stage. Steers granted input beats to each output with no added
   latency, returns ready to the granted input and counts finished packets. */
`timescale 1ns/1ps

module xbar_output_mux (
  input  logic                           clk,
  input  logic                           reset,
  input  xbar_pkg::stream_beat_t         i_in_beat [xbar_pkg::NUM_PORTS],
  input  logic [xbar_pkg::NUM_PORTS-1:0] i_in_valid,
  output logic [xbar_pkg::NUM_PORTS-1:0] o_in_ready,
  input  logic [xbar_pkg::NUM_PORTS-1:0] i_grant [xbar_pkg::NUM_PORTS],   // Per output
  output xbar_pkg::stream_beat_t         o_out_beat [xbar_pkg::NUM_PORTS],
  output logic [xbar_pkg::NUM_PORTS-1:0] o_out_valid,
  input  logic [xbar_pkg::NUM_PORTS-1:0] i_out_ready,
  output logic [xbar_pkg::NUM_PORTS-1:0] o_accept,
  output logic [xbar_pkg::NUM_PORTS-1:0] o_accept_last,
  output logic [xbar_pkg::REG_DW-1:0]    o_pkt_cnt [xbar_pkg::NUM_PORTS]
);
  import xbar_pkg::*;

  logic [NUM_PORTS-1:0] out_done;

  // Output side, idle outputs show a zero beat
  always_comb begin
    for (int o = 0; o < NUM_PORTS; o++) begin
      o_out_beat[o]  = '0;
      o_out_valid[o] = 1'b0;
      for (int i = 0; i < NUM_PORTS; i++) begin
        if (i_grant[o][i]) begin
          o_out_beat[o]  = i_in_beat[i];
          o_out_valid[o] = i_in_valid[i];
        end
      end
      out_done[o] = o_out_valid[o] && i_out_ready[o] && o_out_beat[o].last;
    end
  end

  // Input side, ready only comes through a held grant
  always_comb begin
    for (int i = 0; i < NUM_PORTS; i++) begin
      o_in_ready[i] = 1'b0;
      for (int o = 0; o < NUM_PORTS; o++) begin
        if (i_grant[o][i]) begin
          o_in_ready[i] = i_out_ready[o];
        end
      end
      o_accept[i]      = i_in_valid[i] && o_in_ready[i];
      o_accept_last[i] = o_accept[i] && i_in_beat[i].last;
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      for (int o = 0; o < NUM_PORTS; o++) begin
        o_pkt_cnt[o] <= '0;
      end
    end else begin
      for (int o = 0; o < NUM_PORTS; o++) begin
        if (out_done[o]) begin
          o_pkt_cnt[o] <= o_pkt_cnt[o] + 1'b1;   // Counts on the last beat edge
        end
      end
    end
  end

endmodule

// ==== xbar_top.sv ====
/* Top level of the two-port packet switch. Joins the register block, the
   per-input route decoders, the per-output arbiters and the output stage. */
`timescale 1ns/1ps

module xbar_top (
  input  logic                           clk,
  input  logic                           reset,
  input  logic                           i_reg_wr_req,
  input  logic [xbar_pkg::REG_AW-1:0]    i_reg_wr_addr,
  input  logic [xbar_pkg::REG_DW-1:0]    i_reg_wr_data,
  input  logic                           i_reg_rd_req,
  input  logic [xbar_pkg::REG_AW-1:0]    i_reg_rd_addr,
  output logic [xbar_pkg::REG_DW-1:0]    o_reg_rd_data,
  output logic                           o_reg_rd_resp,
  input  xbar_pkg::stream_beat_t         i_in_beat [xbar_pkg::NUM_PORTS],
  input  logic [xbar_pkg::NUM_PORTS-1:0] i_in_valid,
  output logic [xbar_pkg::NUM_PORTS-1:0] o_in_ready,
  output xbar_pkg::stream_beat_t         o_out_beat [xbar_pkg::NUM_PORTS],
  output logic [xbar_pkg::NUM_PORTS-1:0] o_out_valid,
  input  logic [xbar_pkg::NUM_PORTS-1:0] i_out_ready
);
  import xbar_pkg::*;

  logic [LOCAL_W-1:0]   local_addr;
  route_table_t         route_table;
  logic [REG_DW-1:0]    pkt_cnt [NUM_PORTS];
  route_req_t           req [NUM_PORTS];          // Indexed by input
  logic [NUM_PORTS-1:0] grant [NUM_PORTS];        // Indexed by output, one-hot over inputs
  logic [NUM_PORTS-1:0] accept;
  logic [NUM_PORTS-1:0] accept_last;

  xbar_regs u_regs (
    .clk           (clk),
    .reset         (reset),
    .i_reg_wr_req  (i_reg_wr_req),
    .i_reg_wr_addr (i_reg_wr_addr),
    .i_reg_wr_data (i_reg_wr_data),
    .i_reg_rd_req  (i_reg_rd_req),
    .i_reg_rd_addr (i_reg_rd_addr),
    .o_reg_rd_data (o_reg_rd_data),
    .o_reg_rd_resp (o_reg_rd_resp),
    .i_pkt_cnt     (pkt_cnt),
    .o_local_addr  (local_addr),
    .o_route_table (route_table)
  );

  for (genvar p = 0; p < NUM_PORTS; p++) begin : g_port
    // Decoder for input p
    xbar_route_decode u_route_decode (
      .clk           (clk),
      .reset         (reset),
      .i_beat        (i_in_beat[p]),
      .i_valid       (i_in_valid[p]),
      .i_accept      (accept[p]),
      .i_local_addr  (local_addr),
      .i_route_table (route_table),
      .o_req         (req[p])
    );

    // Arbiter for output p
    xbar_arbiter u_arbiter (
      .clk           (clk),
      .reset         (reset),
      .i_port_id     (PORT_W'(p)),
      .i_req         (req),
      .i_accept_last (accept_last),
      .o_grant       (grant[p]),
      .o_busy        ()
    );
  end

  xbar_output_mux u_output_mux (
    .clk           (clk),
    .reset         (reset),
    .i_in_beat     (i_in_beat),
    .i_in_valid    (i_in_valid),
    .o_in_ready    (o_in_ready),
    .i_grant       (grant),
    .o_out_beat    (o_out_beat),
    .o_out_valid   (o_out_valid),
    .i_out_ready   (i_out_ready),
    .o_accept      (accept),
    .o_accept_last (accept_last),
    .o_pkt_cnt     (pkt_cnt)
  );

endmodule

// ==== tb_xbar.sv ====
/* Self-checking testbench for the two-port packet switch. Covers register
   access, routing, contention, back-pressure and packet counters. */
`timescale 1ns/1ps

module tb_xbar;
  import xbar_pkg::*;

  localparam int ROUTE_PKTS     = 24;
  localparam int CONTEND_PKTS   = 24;   // Six per input per output
  localparam int BP_PKTS        = 20;
  localparam int TOTAL_PKTS     = ROUTE_PKTS + CONTEND_PKTS + BP_PKTS;
  localparam int TIMEOUT_CYCLES = 200 * TOTAL_PKTS + 2000;

  logic                 clk      = 1'b0;
  logic                 reset    = 1'b1;
  logic                 wr_req   = 1'b0;
  logic [REG_AW-1:0]    wr_addr  = '0;
  logic [REG_DW-1:0]    wr_data  = '0;
  logic                 rd_req   = 1'b0;
  logic [REG_AW-1:0]    rd_addr  = '0;
  logic [REG_DW-1:0]    rd_data;
  logic                 rd_resp;
  stream_beat_t         in_beat [NUM_PORTS] = '{default: '0};
  logic [NUM_PORTS-1:0] in_valid  = '0;
  logic [NUM_PORTS-1:0] in_ready;
  stream_beat_t         out_beat [NUM_PORTS];
  logic [NUM_PORTS-1:0] out_valid;
  logic [NUM_PORTS-1:0] out_ready = '1;

  string                   test_name = "reset";
  logic [31:0]             rng       = 32'd79662;
  logic [31:0]             rdy_bits;
  bit                      throttle  = 1'b0;
  logic [LOCAL_W-1:0]      tb_local  = '0;
  logic [ROUTE_ENTRIES-1:0] tb_table = '0;
  int                      pkt_sent  = 0;
  stream_beat_t            tx_q  [NUM_PORTS][$];             // Beats waiting per input
  stream_beat_t            exp_q [NUM_PORTS*NUM_PORTS][$];   // Index output * 2 + input
  bit   [NUM_PORTS-1:0]    mon_in_pkt = '0;
  int                      mon_src   [NUM_PORTS] = '{default: 0};
  bit   [NUM_PORTS-1:0]    stall      = '0;
  stream_beat_t            held      [NUM_PORTS];
  int                      delivered [NUM_PORTS] = '{default: 0};
  stream_beat_t            mon_beat;
  stream_beat_t            mon_exp;
  int                      mon_q;

  xbar_top u_xbar_top (
    .clk           (clk),
    .reset         (reset),
    .i_reg_wr_req  (wr_req),
    .i_reg_wr_addr (wr_addr),
    .i_reg_wr_data (wr_data),
    .i_reg_rd_req  (rd_req),
    .i_reg_rd_addr (rd_addr),
    .o_reg_rd_data (rd_data),
    .o_reg_rd_resp (rd_resp),
    .i_in_beat     (in_beat),
    .i_in_valid    (in_valid),
    .o_in_ready    (in_ready),
    .o_out_beat    (out_beat),
    .o_out_valid   (out_valid),
    .i_out_ready   (out_ready)
  );

  initial begin
    forever #4 clk = ~clk;
  end

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  function automatic logic [31:0] next_rand();
    rng = xorshift32(rng);
    return rng;
  endfunction

  task automatic stop_with_error(input string what);
    $display("ERROR in test %s: %s", test_name, what);
    $display("TEST FAIL");
    $fatal(1, "simulation stopped on error");
  endtask

  task automatic show_mismatch(input string what, input logic [64:0] exp_v,
                               input logic [64:0] act_v);
    $display("MISMATCH test=%s check=%s expected=%h actual=%h", test_name, what, exp_v, act_v);
    $display("TEST FAIL");
    $fatal(1, "simulation stopped on error");
  endtask

  task automatic reg_write(input logic [REG_AW-1:0] addr, input logic [REG_DW-1:0] data);
    @(posedge clk);
    wr_req  <= 1'b1;
    wr_addr <= addr;
    wr_data <= data;
    @(posedge clk);
    wr_req  <= 1'b0;
  endtask

  // Response must show exactly one cycle after the request cycle
  task automatic reg_read(input logic [REG_AW-1:0] addr, output logic [REG_DW-1:0] data);
    @(posedge clk);
    rd_req  <= 1'b1;
    rd_addr <= addr;
    @(posedge clk);
    rd_req  <= 1'b0;
    assert (!rd_resp) else stop_with_error("read response came in the request cycle");
    @(posedge clk);
    assert (rd_resp) else stop_with_error("read response missing one cycle after request");
    data = rd_data;
  endtask

  task automatic check_reg(input logic [REG_AW-1:0] addr, input logic [REG_DW-1:0] exp_v,
                           input string what);
    logic [REG_DW-1:0] data;
    reg_read(addr, data);
    assert (data == exp_v) else show_mismatch(what, 65'(exp_v), 65'(data));
  endtask

  task automatic expect_no_response(input logic [REG_AW-1:0] addr);
    @(posedge clk);
    rd_req  <= 1'b1;
    rd_addr <= addr;
    @(posedge clk);
    rd_req  <= 1'b0;
    repeat (4) begin
      @(posedge clk);
      assert (!rd_resp) else stop_with_error("unmapped read got a response");
    end
  endtask

  // Routing rule worked out from the testbench copy of the registers
  function automatic int expected_port(input logic [DST_W-1:0] dst);
    if (dst[DST_W-1 -: LOCAL_W] != tb_local) begin
      return 0;   // Uplink
    end
    return int'(tb_table[dst[ROUTE_IDX_W-1:0]]);
  endfunction

  task automatic build_pkt(input int p, input logic [DST_W-1:0] dst, input int nbeats);
    stream_beat_t b;
    int           q;
    q = expected_port(dst) * NUM_PORTS + p;
    b.data.hdr.dst    = dst;
    b.data.hdr.src    = 16'(p);
    b.data.hdr.length = 16'(nbeats);
    b.data.hdr.rsvd   = 16'(pkt_sent);
    b.last            = (nbeats == 1);
    tx_q[p].push_back(b);
    exp_q[q].push_back(b);
    for (int i = 1; i < nbeats; i++) begin
      b.data.raw = {next_rand(), next_rand()};
      b.last     = (i == nbeats - 1);
      tx_q[p].push_back(b);
      exp_q[q].push_back(b);
    end
    pkt_sent++;
  endtask

  function automatic bit traffic_idle();
    int n;
    n = 0;
    for (int p = 0; p < NUM_PORTS; p++) begin
      n += tx_q[p].size();
    end
    for (int q = 0; q < NUM_PORTS * NUM_PORTS; q++) begin
      n += exp_q[q].size();
    end
    return (n == 0) && (in_valid == '0);
  endfunction

  task automatic wait_drain();
    do @(negedge clk); while (!traffic_idle());
  endtask

  // Input drivers, next beat goes out once the current one transfers
  always @(posedge clk) begin
    for (int p = 0; p < NUM_PORTS; p++) begin
      if (reset) begin
        in_valid[p] <= 1'b0;
      end else if (!in_valid[p] || in_ready[p]) begin
        if (tx_q[p].size() > 0) begin
          in_beat[p]  <= tx_q[p].pop_front();
          in_valid[p] <= 1'b1;
        end else begin
          in_valid[p] <= 1'b0;
        end
      end
    end
  end

  always @(posedge clk) begin
    if (reset || !throttle) begin
      out_ready <= '1;
    end else begin
      rdy_bits = next_rand();
      out_ready <= rdy_bits[NUM_PORTS-1:0];
    end
  end

  // Output monitor, locks onto the source named in each header
  always @(posedge clk) begin
    if (!reset) begin
      // No storage inside, so every input transfer leaves on an output in the same cycle
      assert ($countones(in_valid & in_ready) == $countones(out_valid & out_ready)) else
        stop_with_error("input and output transfers differ in one cycle");
      for (int o = 0; o < NUM_PORTS; o++) begin
        mon_beat = out_beat[o];
        if (stall[o]) begin
          assert (out_valid[o]) else stop_with_error("output valid dropped while stalled");
          assert (mon_beat == held[o]) else
            show_mismatch("stalled beat stable", 65'(held[o]), 65'(mon_beat));
        end
        stall[o] = out_valid[o] && !out_ready[o];
        held[o]  = mon_beat;
        if (out_valid[o] && out_ready[o]) begin
          if (!mon_in_pkt[o]) begin
            mon_src[o] = int'(mon_beat.data.hdr.src[PORT_W-1:0]);
          end
          mon_q = o * NUM_PORTS + mon_src[o];
          if (exp_q[mon_q].size() == 0) begin
            stop_with_error($sformatf("beat on output %0d with no packet expected", o));
          end else begin
            mon_exp = exp_q[mon_q].pop_front();
            assert (mon_beat == mon_exp) else
              show_mismatch($sformatf("output %0d beat", o), 65'(mon_exp), 65'(mon_beat));
            mon_in_pkt[o] = !mon_beat.last;
            if (mon_beat.last) begin
              delivered[o]++;
            end
          end
        end
      end
    end
  end

  initial begin
    repeat (TIMEOUT_CYCLES) @(posedge clk);
    stop_with_error("watchdog timeout, traffic never drained");
  end

  initial begin
    logic [31:0]      r;
    logic [DST_W-1:0] dst;
    repeat (2) @(posedge clk);
    reset <= 1'b0;

    test_name = "identity";
    check_reg(REG_VERSION, 32'd1, "version");
    check_reg(REG_NUM_PORTS, 32'd2, "port count");
    check_reg(REG_LOCAL_ADDR, '0, "local address after reset");
    expect_no_response(14'h00c);
    expect_no_response(14'h012);   // Misaligned route address
    expect_no_response(14'h100);

    test_name = "register_rw";
    r = next_rand();
    tb_local = r[LOCAL_W-1:0];
    reg_write(REG_LOCAL_ADDR, REG_DW'(tb_local));
    for (int k = 0; k < ROUTE_ENTRIES; k++) begin
      r = next_rand();
      tb_table[k] = (k < 2) ? k[0] : r[0];   // Entries 0 and 1 pinned to both outputs
      reg_write(REG_ROUTE_BASE + REG_AW'(4 * k), {r[31:1], tb_table[k]});
    end
    check_reg(REG_LOCAL_ADDR, REG_DW'(tb_local), "local address");
    for (int k = 0; k < ROUTE_ENTRIES; k++) begin
      check_reg(REG_ROUTE_BASE + REG_AW'(4 * k), REG_DW'(tb_table[k]), "route entry");
    end

    test_name = "routing";
    @(negedge clk);
    for (int n = 0; n < ROUTE_PKTS; n++) begin
      r = next_rand();
      dst = r[15:0];
      if (r[16]) begin
        dst[DST_W-1 -: LOCAL_W] = tb_local;
      end
      build_pkt(int'(r[20]), dst, 1 + int'(r[19:17]) % 6);
    end
    wait_drain();

    test_name = "contention";
    for (int n = 0; n < CONTEND_PKTS / 4; n++) begin
      for (int p = 0; p < NUM_PORTS; p++) begin
        r = next_rand();
        build_pkt(p, {~tb_local, 8'h00}, 1 + int'(r[1:0]));
      end
    end
    for (int n = 0; n < CONTEND_PKTS / 4; n++) begin
      for (int p = 0; p < NUM_PORTS; p++) begin
        r = next_rand();
        build_pkt(p, {tb_local, 8'h01}, 1 + int'(r[1:0]));
      end
    end
    wait_drain();

    test_name = "back_pressure";
    throttle = 1'b1;
    for (int n = 0; n < BP_PKTS; n++) begin
      r = next_rand();
      dst = r[15:0];
      if (r[16]) begin
        dst[DST_W-1 -: LOCAL_W] = tb_local;
      end
      build_pkt(int'(r[20]), dst, 1 + int'(r[19:17]) % 6);
    end
    wait_drain();
    throttle = 1'b0;

    test_name = "counters";
    for (int j = 0; j < NUM_PORTS; j++) begin
      check_reg(REG_PKT_CNT_BASE + REG_AW'(4 * j), REG_DW'(delivered[j]), "packet counter");
    end

    $display("TEST PASS");
    $finish;
  end

endmodule

// ==== all.f ====
xbar_pkg.sv
xbar_regs.sv
xbar_route_decode.sv
xbar_arbiter.sv
xbar_output_mux.sv
xbar_top.sv
tb_xbar.sv

// ==== run.sh ====
#!/bin/sh
# Builds the switch testbench with Verilator, runs it and checks the log

rm -rf obj_dir
verilator --binary --timing --assert -f all.f --top-module tb_xbar > build.log 2>&1 \
  || { cat build.log; echo "Build failed"; exit 1; }
./obj_dir/Vtb_xbar > sim.log 2>&1 || echo "Simulator exited with an error"
cat sim.log
grep -q "TEST FAIL" sim.log && { echo "Simulation failed"; exit 1; }
grep -q "TEST PASS" sim.log || { echo "Simulation ended without a result"; exit 1; }
echo "Simulation passed"
